/* design/decode_pkg.sv */
package decode_pkg;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // one-hot alu_op bit positions
    localparam int unsigned ALU_ADD  = 0;
    localparam int unsigned ALU_SUB  = 1;
    localparam int unsigned ALU_SLT  = 2;
    localparam int unsigned ALU_SLTU = 3;
    localparam int unsigned ALU_AND  = 4;
    localparam int unsigned ALU_NOR  = 5;
    localparam int unsigned ALU_OR   = 6;
    localparam int unsigned ALU_XOR  = 7;
    localparam int unsigned ALU_SLL  = 8;
    localparam int unsigned ALU_SRL  = 9;
    localparam int unsigned ALU_SRA  = 10;
    localparam int unsigned ALU_LUI  = 11;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic [3:0]  we;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_write_t;

    // blk_valid marks a load whose data is not back yet
    typedef struct packed {
        logic [3:0]  fwd_valid;
        logic [4:0]  dest;
        logic [31:0] data;
        logic        blk_valid;
    } fwd_t;

    typedef struct packed {
        logic [11:0] alu_op;
        logic        load_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_uimm;
        logic        src2_is_8;
        logic        gr_we;
        logic        mem_we;
        logic [4:0]  dest;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic [25:0] jidx;
        logic        is_beq;
        logic        is_bne;
        logic        is_j;
        logic        is_jal;
        logic        is_jr;
        logic        is_jalr;
    } dec_t;

    typedef struct packed {
        logic [11:0] alu_op;
        logic        load_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_uimm;
        logic        src2_is_8;
        logic        gr_we;
        logic        mem_we;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [31:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic        leaving;
        logic        stall;
        logic        taken;
        logic [31:0] target;
    } br_t;

endpackage

/* design/fetch_latch.sv */
`timescale 1ns/1ps

module fetch_latch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::fs_to_ds_t fs_to_ds,
    input  logic                  ready_go,
    input  logic                  es_allowin,
    output logic                  ds_valid,
    output logic                  ds_allowin,
    output decode_pkg::fs_to_ds_t inst_bundle
);

    // empty, or the held item leaves this cycle
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            inst_bundle <= fs_to_ds;
        end
    end

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::fs_to_ds_t inst_bundle,
    output decode_pkg::dec_t      dec
);

    logic [31:0] inst;
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [5:0]  func;
    logic        special;

    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_j, inst_jal, inst_jr, inst_jalr;
    logic dst_is_r31;
    logic dst_is_rt;

    assign inst    = inst_bundle.inst;
    assign op      = inst[31:26];
    assign rs      = inst[25:21];
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];
    assign sa      = inst[10:6];
    assign func    = inst[5:0];
    assign special = (op == decode_pkg::OP_SPECIAL);

    // register forms need sa == 0
    assign inst_addu = special && func == decode_pkg::FN_ADDU && sa == 5'd0;
    assign inst_subu = special && func == decode_pkg::FN_SUBU && sa == 5'd0;
    assign inst_slt  = special && func == decode_pkg::FN_SLT  && sa == 5'd0;
    assign inst_sltu = special && func == decode_pkg::FN_SLTU && sa == 5'd0;
    assign inst_and  = special && func == decode_pkg::FN_AND  && sa == 5'd0;
    assign inst_or   = special && func == decode_pkg::FN_OR   && sa == 5'd0;
    assign inst_xor  = special && func == decode_pkg::FN_XOR  && sa == 5'd0;
    assign inst_nor  = special && func == decode_pkg::FN_NOR  && sa == 5'd0;

    // shifts by immediate keep rs at zero
    assign inst_sll = special && func == decode_pkg::FN_SLL && rs == 5'd0;
    assign inst_srl = special && func == decode_pkg::FN_SRL && rs == 5'd0;
    assign inst_sra = special && func == decode_pkg::FN_SRA && rs == 5'd0;

    assign inst_addiu = (op == decode_pkg::OP_ADDIU);
    assign inst_slti  = (op == decode_pkg::OP_SLTI);
    assign inst_sltiu = (op == decode_pkg::OP_SLTIU);
    assign inst_andi  = (op == decode_pkg::OP_ANDI);
    assign inst_ori   = (op == decode_pkg::OP_ORI);
    assign inst_xori  = (op == decode_pkg::OP_XORI);
    assign inst_lui   = (op == decode_pkg::OP_LUI) && rs == 5'd0;
    assign inst_lw    = (op == decode_pkg::OP_LW);
    assign inst_sw    = (op == decode_pkg::OP_SW);

    assign inst_beq  = (op == decode_pkg::OP_BEQ);
    assign inst_bne  = (op == decode_pkg::OP_BNE);
    assign inst_j    = (op == decode_pkg::OP_J);
    assign inst_jal  = (op == decode_pkg::OP_JAL);
    assign inst_jr   = special && func == decode_pkg::FN_JR
                       && rt == 5'd0 && rd == 5'd0 && sa == 5'd0;
    assign inst_jalr = special && func == decode_pkg::FN_JALR && rt == 5'd0;

    assign dst_is_r31 = inst_jal;
    assign dst_is_rt  = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                        | inst_xori | inst_lui | inst_lw;

    always_comb begin
        dec = '0;

        // link forms add 8 to pc in the ALU
        dec.alu_op[decode_pkg::ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw
                                           | inst_jal | inst_jalr;
        dec.alu_op[decode_pkg::ALU_SUB]  = inst_subu;
        dec.alu_op[decode_pkg::ALU_SLT]  = inst_slt | inst_slti;
        dec.alu_op[decode_pkg::ALU_SLTU] = inst_sltu | inst_sltiu;
        dec.alu_op[decode_pkg::ALU_AND]  = inst_and | inst_andi;
        dec.alu_op[decode_pkg::ALU_NOR]  = inst_nor;
        dec.alu_op[decode_pkg::ALU_OR]   = inst_or | inst_ori;
        dec.alu_op[decode_pkg::ALU_XOR]  = inst_xor | inst_xori;
        dec.alu_op[decode_pkg::ALU_SLL]  = inst_sll;
        dec.alu_op[decode_pkg::ALU_SRL]  = inst_srl;
        dec.alu_op[decode_pkg::ALU_SRA]  = inst_sra;
        dec.alu_op[decode_pkg::ALU_LUI]  = inst_lui;

        dec.load_op      = inst_lw;
        dec.src1_is_sa   = inst_sll | inst_srl | inst_sra;
        dec.src1_is_pc   = inst_jal | inst_jalr;
        dec.src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
        dec.src2_is_uimm = inst_andi | inst_ori | inst_xori;
        dec.src2_is_8    = inst_jal | inst_jalr;
        dec.gr_we        = ~(inst_sw | inst_beq | inst_bne | inst_j | inst_jr);
        dec.mem_we       = inst_sw;
        dec.dest         = dst_is_r31 ? 5'd31 : (dst_is_rt ? rt : rd);

        dec.rs   = rs;
        dec.rt   = rt;
        dec.imm  = inst[15:0];
        dec.jidx = inst[25:0];

        dec.is_beq  = inst_beq;
        dec.is_bne  = inst_bne;
        dec.is_j    = inst_j;
        dec.is_jal  = inst_jal;
        dec.is_jr   = inst_jr;
        dec.is_jalr = inst_jalr;
    end

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  logic [4:0]            raddr1,
    input  logic [4:0]            raddr2,
    output logic [31:0]           rdata1,
    output logic [31:0]           rdata2,
    input  decode_pkg::wb_write_t wr
);

    logic [31:0] rf [32];

    // byte-lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr.we[i]) begin
                rf[wr.addr][8*i +: 8] <= wr.data[8*i +: 8];
            end
        end
    end

    // r0 is hardwired to zero on read
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

/* design/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  logic                  clk,
    input  logic [4:0]            rs,
    input  logic [4:0]            rt,
    input  decode_pkg::wb_write_t wb,
    input  decode_pkg::fwd_t      es_fwd,
    input  decode_pkg::fwd_t      ms_fwd,
    output logic [31:0]           rs_value,
    output logic [31:0]           rt_value,
    output logic                  ready_go
);

    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        es_block;
    logic        ms_block;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb)
    );

    // each lane tries es first, then ms, then wb, then the file
    function automatic logic [31:0] pick(
        input logic [4:0]            src,
        input logic [31:0]           rf_val,
        input decode_pkg::fwd_t      es,
        input decode_pkg::fwd_t      ms,
        input decode_pkg::wb_write_t w
    );
        logic [31:0] v;
        v = rf_val;
        for (int i = 0; i < 4; i++) begin
            if (es.fwd_valid[i] && es.dest == src) begin
                v[8*i +: 8] = es.data[8*i +: 8];
            end else if (ms.fwd_valid[i] && ms.dest == src) begin
                v[8*i +: 8] = ms.data[8*i +: 8];
            end else if (w.we[i] && w.addr == src) begin
                v[8*i +: 8] = w.data[8*i +: 8];
            end
        end
        return v;
    endfunction

    assign rs_value = pick(rs, rf_rdata1, es_fwd, ms_fwd, wb);
    assign rt_value = pick(rt, rf_rdata2, es_fwd, ms_fwd, wb);

    // load-use hazard
    assign es_block = es_fwd.blk_valid && (es_fwd.dest == rs || es_fwd.dest == rt);
    assign ms_block = ms_fwd.blk_valid && (ms_fwd.dest == rs || ms_fwd.dest == rt);
    assign ready_go = !(es_block || ms_block);

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  decode_pkg::dec_t dec,
    input  logic [31:0]      pc,
    input  logic [31:0]      rs_value,
    input  logic [31:0]      rt_value,
    input  logic             ds_valid,
    input  logic             ready_go,
    input  logic             es_allowin,
    output decode_pkg::br_t  br
);

    logic [31:0] seq_pc;
    logic [31:0] br_offset;
    logic        rs_eq_rt;
    logic        is_branch;
    logic        taken;
    logic [31:0] target;

    assign seq_pc    = pc + 32'd4;
    assign br_offset = {{14{dec.imm[15]}}, dec.imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);

    assign is_branch = ds_valid && (dec.is_beq | dec.is_bne | dec.is_j
                                    | dec.is_jal | dec.is_jr | dec.is_jalr);

    // jumps are unconditional
    assign taken = ds_valid && ((dec.is_beq && rs_eq_rt)
                                || (dec.is_bne && !rs_eq_rt)
                                || dec.is_j || dec.is_jal
                                || dec.is_jr || dec.is_jalr);

    always_comb begin
        if (dec.is_beq || dec.is_bne) begin
            target = seq_pc + br_offset;
        end else if (dec.is_jr || dec.is_jalr) begin
            target = rs_value;
        end else begin
            // j and jal stay in the 256MB region of the delay slot
            target = {seq_pc[31:28], dec.jidx, 2'b00};
        end
    end

    assign br.leaving = taken && ready_go && es_allowin;
    assign br.stall   = is_branch && !ready_go;
    assign br.taken   = taken;
    assign br.target  = target;

endmodule

/* design/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fs_to_ds_valid,
    input  decode_pkg::fs_to_ds_t fs_to_ds,
    input  logic                  es_allowin,
    input  decode_pkg::wb_write_t wb,
    input  decode_pkg::fwd_t      es_fwd,
    input  decode_pkg::fwd_t      ms_fwd,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::ds_to_es_t ds_to_es,
    output decode_pkg::br_t       br
);

    logic                  ds_valid;
    logic                  ready_go;
    decode_pkg::fs_to_ds_t inst_bundle;
    decode_pkg::dec_t      dec;
    logic [31:0]           rs_value;
    logic [31:0]           rt_value;

    fetch_latch u_fetch_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ready_go       (ready_go),
        .es_allowin     (es_allowin),
        .ds_valid       (ds_valid),
        .ds_allowin     (ds_allowin),
        .inst_bundle    (inst_bundle)
    );

    inst_decoder u_inst_decoder (
        .inst_bundle (inst_bundle),
        .dec         (dec)
    );

    operand_bypass u_operand_bypass (
        .clk      (clk),
        .rs       (dec.rs),
        .rt       (dec.rt),
        .wb       (wb),
        .es_fwd   (es_fwd),
        .ms_fwd   (ms_fwd),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready_go (ready_go)
    );

    branch_unit u_branch_unit (
        .dec        (dec),
        .pc         (inst_bundle.pc),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .ds_valid   (ds_valid),
        .ready_go   (ready_go),
        .es_allowin (es_allowin),
        .br         (br)
    );

    assign ds_to_es_valid = ds_valid && ready_go;

    // bundle for execute
    always_comb begin
        ds_to_es.alu_op       = dec.alu_op;
        ds_to_es.load_op      = dec.load_op;
        ds_to_es.src1_is_sa   = dec.src1_is_sa;
        ds_to_es.src1_is_pc   = dec.src1_is_pc;
        ds_to_es.src2_is_imm  = dec.src2_is_imm;
        ds_to_es.src2_is_uimm = dec.src2_is_uimm;
        ds_to_es.src2_is_8    = dec.src2_is_8;
        ds_to_es.gr_we        = dec.gr_we;
        ds_to_es.mem_we       = dec.mem_we;
        ds_to_es.dest         = dec.dest;
        ds_to_es.imm          = dec.imm;
        ds_to_es.rs_value     = rs_value;
        ds_to_es.rt_value     = rt_value;
        ds_to_es.pc           = inst_bundle.pc;
    end

endmodule

/* testbench/tb_decode_model.svh */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// expected control fields of one instruction
function automatic decode_pkg::dec_t model_decode(input logic [31:0] inst);
    decode_pkg::dec_t d;
    logic [5:0]       opc;
    logic             imm_form;
    d        = '0;
    opc      = inst[31:26];
    d.rs     = inst[25:21];
    d.rt     = inst[20:16];
    d.imm    = inst[15:0];
    d.jidx   = inst[25:0];
    d.dest   = inst[15:11];
    imm_form = (opc >= 6'h09) && (opc <= 6'h0f);
    if (opc == 6'h00) begin
        case (inst[5:0])
            6'h21: d.alu_op[decode_pkg::ALU_ADD]  = 1'b1;
            6'h23: d.alu_op[decode_pkg::ALU_SUB]  = 1'b1;
            6'h2a: d.alu_op[decode_pkg::ALU_SLT]  = 1'b1;
            6'h2b: d.alu_op[decode_pkg::ALU_SLTU] = 1'b1;
            6'h24: d.alu_op[decode_pkg::ALU_AND]  = 1'b1;
            6'h25: d.alu_op[decode_pkg::ALU_OR]   = 1'b1;
            6'h26: d.alu_op[decode_pkg::ALU_XOR]  = 1'b1;
            6'h27: d.alu_op[decode_pkg::ALU_NOR]  = 1'b1;
            6'h00: d.alu_op[decode_pkg::ALU_SLL]  = 1'b1;
            6'h02: d.alu_op[decode_pkg::ALU_SRL]  = 1'b1;
            6'h03: d.alu_op[decode_pkg::ALU_SRA]  = 1'b1;
            6'h08: d.is_jr   = 1'b1;
            6'h09: d.is_jalr = 1'b1;
            default: ;
        endcase
    end else begin
        case (opc)
            6'h09: d.alu_op[decode_pkg::ALU_ADD]  = 1'b1;
            6'h0a: d.alu_op[decode_pkg::ALU_SLT]  = 1'b1;
            6'h0b: d.alu_op[decode_pkg::ALU_SLTU] = 1'b1;
            6'h0c: d.alu_op[decode_pkg::ALU_AND]  = 1'b1;
            6'h0d: d.alu_op[decode_pkg::ALU_OR]   = 1'b1;
            6'h0e: d.alu_op[decode_pkg::ALU_XOR]  = 1'b1;
            6'h0f: d.alu_op[decode_pkg::ALU_LUI]  = 1'b1;
            6'h23: d.load_op = 1'b1;
            6'h2b: d.mem_we  = 1'b1;
            6'h04: d.is_beq  = 1'b1;
            6'h05: d.is_bne  = 1'b1;
            6'h02: d.is_j    = 1'b1;
            6'h03: d.is_jal  = 1'b1;
            default: ;
        endcase
    end
    // address and link arithmetic also go through the adder
    d.alu_op[decode_pkg::ALU_ADD] |= d.load_op | d.mem_we | d.is_jal | d.is_jalr;
    d.src1_is_sa   = d.alu_op[decode_pkg::ALU_SLL] | d.alu_op[decode_pkg::ALU_SRL]
                     | d.alu_op[decode_pkg::ALU_SRA];
    d.src1_is_pc   = d.is_jal | d.is_jalr;
    d.src2_is_8    = d.is_jal | d.is_jalr;
    d.src2_is_uimm = (opc >= 6'h0c) && (opc <= 6'h0e);
    d.src2_is_imm  = (imm_form && !d.src2_is_uimm) | d.load_op | d.mem_we;
    d.gr_we        = !(d.mem_we | d.is_beq | d.is_bne | d.is_j | d.is_jr);
    if (d.is_jal) begin
        d.dest = 5'd31;
    end else if (imm_form || d.load_op) begin
        d.dest = inst[20:16];
    end
    return d;
endfunction

// a load still in execute or memory holds its consumer back
function automatic logic model_ready(input logic [31:0] inst,
                                     input decode_pkg::fwd_t es,
                                     input decode_pkg::fwd_t ms);
    logic es_hit;
    logic ms_hit;
    es_hit = es.blk_valid && (es.dest == inst[25:21] || es.dest == inst[20:16]);
    ms_hit = ms.blk_valid && (ms.dest == inst[25:21] || ms.dest == inst[20:16]);
    return !(es_hit || ms_hit);
endfunction

// youngest producer wins in each lane
function automatic logic [31:0] model_operand(input logic [4:0]            src,
                                              input logic [31:0]           file_val,
                                              input decode_pkg::fwd_t      es,
                                              input decode_pkg::fwd_t      ms,
                                              input decode_pkg::wb_write_t w);
    logic [31:0] v;
    for (int lane = 0; lane < 4; lane++) begin
        if (es.fwd_valid[lane] && es.dest == src) begin
            v[8*lane +: 8] = es.data[8*lane +: 8];
        end else if (ms.fwd_valid[lane] && ms.dest == src) begin
            v[8*lane +: 8] = ms.data[8*lane +: 8];
        end else if (w.we[lane] && w.addr == src) begin
            v[8*lane +: 8] = w.data[8*lane +: 8];
        end else begin
            v[8*lane +: 8] = file_val[8*lane +: 8];
        end
    end
    return v;
endfunction

function automatic decode_pkg::br_t model_branch(input decode_pkg::dec_t d,
                                                 input logic [31:0]      pc,
                                                 input logic [31:0]      rsv,
                                                 input logic [31:0]      rtv,
                                                 input logic             rg,
                                                 input logic             es_ready);
    decode_pkg::br_t b;
    logic [31:0]     next_pc;
    logic            any_branch;
    next_pc    = pc + 32'd4;
    any_branch = d.is_beq | d.is_bne | d.is_j | d.is_jal | d.is_jr | d.is_jalr;
    b.taken    = (d.is_beq && rsv == rtv) || (d.is_bne && rsv != rtv)
                 || d.is_j || d.is_jal || d.is_jr || d.is_jalr;
    if (d.is_jr || d.is_jalr) begin
        b.target = rsv;
    end else if (d.is_j || d.is_jal) begin
        b.target = {next_pc[31:28], d.jidx, 2'b00};
    end else begin
        b.target = next_pc + {{14{d.imm[15]}}, d.imm, 2'b00};
    end
    b.leaving = b.taken && rg && es_ready;
    b.stall   = any_branch && !rg;
    return b;
endfunction

`endif

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;

    localparam int N_TRANS    = 2000;
    // ten cycles per instruction leaves room for stalls and back-pressure
    localparam int MAX_CYCLES = N_TRANS * 10;

    logic                  clk = 1'b0;
    logic                  reset = 1'b1;
    logic                  fs_to_ds_valid = 1'b0;
    decode_pkg::fs_to_ds_t fs_to_ds = '0;
    logic                  es_allowin = 1'b1;
    decode_pkg::wb_write_t wb = '0;
    decode_pkg::fwd_t      es_fwd = '0;
    decode_pkg::fwd_t      ms_fwd = '0;
    logic                  ds_allowin;
    logic                  ds_to_es_valid;
    decode_pkg::ds_to_es_t ds_to_es;
    decode_pkg::br_t       br;

    // model of the latch and the register file
    logic                  m_valid = 1'b0;
    decode_pkg::fs_to_ds_t m_bundle = '0;
    logic [31:0]           m_rf [32];
    logic [31:0]           lfsr = 32'h4b85;
    int                    issued = 0;
    int                    leave_count = 0;
    int                    cycle_count = 0;
    int                    reset_cycles = 0;
    int                    init_reg = 0;

    `include "tb_decode_model.svh"

    id_stage dut0 (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .es_allowin     (es_allowin),
        .wb             (wb),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .br             (br)
    );

    always #10 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // registers kept to r0..r7 so that bypass and hazards hit often
    function automatic logic [31:0] make_inst();
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        logic [25:0] jidx;
        logic [31:0] inst;
        int          kind;
        kind = rnd(5) % 26;
        rs   = 5'(rnd(3));
        rt   = 5'(rnd(3));
        rd   = 5'(rnd(3));
        sa   = 5'(rnd(5));
        imm  = 16'(rnd(16));
        jidx = 26'(rnd(26));
        case (kind)
            0: inst = {6'h00, rs, rt, rd, 5'd0, 6'h21};
            1: inst = {6'h00, rs, rt, rd, 5'd0, 6'h23};
            2: inst = {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            3: inst = {6'h00, rs, rt, rd, 5'd0, 6'h2b};
            4: inst = {6'h00, rs, rt, rd, 5'd0, 6'h24};
            5: inst = {6'h00, rs, rt, rd, 5'd0, 6'h25};
            6: inst = {6'h00, rs, rt, rd, 5'd0, 6'h26};
            7: inst = {6'h00, rs, rt, rd, 5'd0, 6'h27};
            8: inst = {6'h00, 5'd0, rt, rd, sa, 6'h00};
            9: inst = {6'h00, 5'd0, rt, rd, sa, 6'h02};
            10: inst = {6'h00, 5'd0, rt, rd, sa, 6'h03};
            11: inst = {6'h09, rs, rt, imm};
            12: inst = {6'h0a, rs, rt, imm};
            13: inst = {6'h0b, rs, rt, imm};
            14: inst = {6'h0c, rs, rt, imm};
            15: inst = {6'h0d, rs, rt, imm};
            16: inst = {6'h0e, rs, rt, imm};
            17: inst = {6'h0f, 5'd0, rt, imm};
            18: inst = {6'h23, rs, rt, imm};
            19: inst = {6'h2b, rs, rt, imm};
            20: inst = {6'h04, rs, rt, imm};
            21: inst = {6'h05, rs, rt, imm};
            22: inst = {6'h02, jidx};
            23: inst = {6'h03, jidx};
            24: inst = {6'h00, rs, 15'd0, 6'h08};
            default: inst = {6'h00, rs, 5'd0, rd, 5'd0, 6'h09};
        endcase
        return inst;
    endfunction

    function automatic decode_pkg::fwd_t random_fwd();
        decode_pkg::fwd_t f;
        f.fwd_valid = (rnd(1) != 0) ? 4'(rnd(4)) : 4'h0;
        f.dest      = 5'(rnd(3));
        f.data      = rnd(32);
        f.blk_valid = (rnd(2) == 0);
        return f;
    endfunction

    function automatic decode_pkg::wb_write_t random_wb();
        decode_pkg::wb_write_t w;
        w.we   = (rnd(1) != 0) ? 4'(rnd(4)) : 4'h0;
        w.addr = 5'(rnd(3));
        w.data = rnd(32);
        return w;
    endfunction

    // stage state after this edge from the inputs it sees now
    task automatic model_step(output logic accepted);
        logic allow;
        allow    = !m_valid || (model_ready(m_bundle.inst, es_fwd, ms_fwd) && es_allowin);
        accepted = fs_to_ds_valid && allow;
        for (int i = 0; i < 4; i++) begin
            if (wb.we[i]) begin
                m_rf[wb.addr][8*i +: 8] = wb.data[8*i +: 8];
            end
        end
        if (allow) begin
            m_valid = fs_to_ds_valid;
        end
        if (accepted) begin
            m_bundle = fs_to_ds;
            issued++;
        end
    endtask

    task automatic drive_random(input logic accepted);
        decode_pkg::fs_to_ds_t f;
        // an offered item stays until it is taken
        if (!fs_to_ds_valid || accepted) begin
            f.inst = make_inst();
            // pc[13:2] carries the issue order
            f.pc   = {18'(rnd(18)), 12'(issued), 2'b00};
            fs_to_ds       <= f;
            fs_to_ds_valid <= (rnd(2) != 0) && (issued < N_TRANS);
        end
        es_allowin <= (rnd(2) != 0);
        es_fwd     <= random_fwd();
        ms_fwd     <= random_fwd();
        wb         <= random_wb();
    endtask

    task automatic check_outputs();
        decode_pkg::dec_t d;
        decode_pkg::br_t  eb;
        logic             rg;
        logic [31:0]      rsv;
        logic [31:0]      rtv;
        eb = '0;
        rg = !m_valid || model_ready(m_bundle.inst, es_fwd, ms_fwd);
        check_value("ds_allowin", 32'(ds_allowin), 32'(!m_valid || (rg && es_allowin)));
        check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'(m_valid && rg));
        if (m_valid) begin
            d   = model_decode(m_bundle.inst);
            rsv = model_operand(d.rs, (d.rs == 5'd0) ? 32'd0 : m_rf[d.rs], es_fwd, ms_fwd, wb);
            rtv = model_operand(d.rt, (d.rt == 5'd0) ? 32'd0 : m_rf[d.rt], es_fwd, ms_fwd, wb);
            eb  = model_branch(d, m_bundle.pc, rsv, rtv, rg, es_allowin);
            check_value("alu_op", 32'(ds_to_es.alu_op), 32'(d.alu_op));
            check_value("operand selects",
                        32'({ds_to_es.load_op, ds_to_es.src1_is_sa, ds_to_es.src1_is_pc,
                             ds_to_es.src2_is_imm, ds_to_es.src2_is_uimm, ds_to_es.src2_is_8}),
                        32'({d.load_op, d.src1_is_sa, d.src1_is_pc,
                             d.src2_is_imm, d.src2_is_uimm, d.src2_is_8}));
            check_value("gr_we", 32'(ds_to_es.gr_we), 32'(d.gr_we));
            check_value("mem_we", 32'(ds_to_es.mem_we), 32'(d.mem_we));
            check_value("dest", 32'(ds_to_es.dest), 32'(d.dest));
            check_value("imm", 32'(ds_to_es.imm), 32'(d.imm));
            check_value("pc", ds_to_es.pc, m_bundle.pc);
            check_value("rs_value", ds_to_es.rs_value, rsv);
            check_value("rt_value", ds_to_es.rt_value, rtv);
            if (eb.taken || d.is_beq || d.is_bne) begin
                check_value("br.target", br.target, eb.target);
            end
        end
        check_value("br.taken", 32'(br.taken), 32'(eb.taken));
        check_value("br.leaving", 32'(br.leaving), 32'(eb.leaving));
        check_value("br.stall", 32'(br.stall), 32'(eb.stall));
        if (ds_to_es_valid && es_allowin) begin
            check_value("issue order tag", 32'(ds_to_es.pc[13:2]), 32'(leave_count[11:0]));
            leave_count++;
        end
    endtask

    always @(posedge clk) begin : stimulus
        logic                  accepted;
        decode_pkg::wb_write_t w;
        if (reset) begin
            reset_cycles++;
            if (reset_cycles == 3) begin
                reset <= 1'b0;
            end
        end else begin
            model_step(accepted);
            if (init_reg < 32) begin
                // known contents in every register first
                w.we   = 4'hf;
                w.addr = 5'(init_reg);
                w.data = rnd(32);
                wb    <= w;
                init_reg++;
            end else begin
                drive_random(accepted);
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            check_outputs();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: only %0d of %0d instructions left the stage in %0d cycles",
                     leave_count, N_TRANS, cycle_count);
            $display("TB FAILED");
            $fatal(1, "simulation did not finish in time");
        end
    end

    initial begin
        wait (leave_count == N_TRANS);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+testbench
design/decode_pkg.sv
design/fetch_latch.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/id_stage.sv
testbench/tb_id_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_id_stage -f verilog.f

output=$(./obj_dir/Vtb_id_stage) || true
echo "$output"
echo "$output" | grep -q "TB PASSED"
